//--- dvi_test_top.f
design/video_pkg.sv
design/video_timing.sv
design/color_bars.sv
design/tmds_encoder.sv
design/board_control.sv
design/dvi_test_top.sv
sim/tb_dvi_test_top.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     := --binary --timing
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_dvi_test_top
RTL_TOP    := dvi_test_top
FILELIST   := dvi_test_top.f
BUILD_DIR  := obj_dir
PASS_MSG   := Simulation passed
SOURCES    := $(wildcard design/*.sv) $(wildcard sim/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- sim/tb_dvi_test_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dvi_test_top;

  // one row of the board control table
  typedef struct packed {
    logic [6:0] btn;
    logic user_programn;
    logic wifi_gpio0;
  } board_row_t;

  localparam int frame_limit = video_pkg::h_total * (video_pkg::v_total + 1);
  localparam int reload_cycles = 1 << (video_pkg::reload_delay_bits - 1);

  logic clk_25mhz = 1'b0;
  logic rst_n;
  logic [6:0] btn;
  logic [7:0] led;
  video_pkg::tmds_symbols_t tmds;
  logic user_programn;
  logic wifi_gpio0;

  board_row_t board_rows [5];
  video_pkg::rgb_t bar_colors [8];
  string lane_name [3];
  logic [29:0] captured [video_pkg::h_total];
  int mismatch_count = 0;
  int failure_count = 0;
  int cycles_since_reset = 0;
  int unsigned seed;
  int cycles;
  logic monitor_on = 1'b0;
  logic [7:0] prev_led = 8'b0000_0100;
  logic [9:0] expected_blue;

  dvi_test_top u_dvi_test_top (
    .clk_25mhz     (clk_25mhz),
    .rst_n         (rst_n),
    .btn           (btn),
    .led           (led),
    .tmds          (tmds),
    .user_programn (user_programn),
    .wifi_gpio0    (wifi_gpio0)
  );

  // 25 MHz pixel clock
  always #20 clk_25mhz = ~clk_25mhz;

  always @(posedge clk_25mhz)
  begin
    if (rst_n)
    begin
      cycles_since_reset <= cycles_since_reset + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    mismatch_count++;
    $display("Error %s: expected %0h, actual %0h", name, expected, actual);
  endtask

  task automatic report_timeout(input string what);
    failure_count++;
    $display("Timeout while waiting for %s", what);
    $display("Summary: %0d value mismatches, %0d other failures", mismatch_count,
             failure_count);
    $display("Simulation failed");
    $finish;
  endtask

  // DVI control code for {c1, c0}
  function automatic logic [9:0] control_code(input logic [1:0] c);
    case (c)
      2'b00: return 10'b1101010100;
      2'b01: return 10'b0010101011;
      2'b10: return 10'b0101010100;
      default: return 10'b1010101011;
    endcase
  endfunction

  function automatic logic is_control(input logic [9:0] sym);
    return (sym == video_pkg::ctrl_00) || (sym == video_pkg::ctrl_01) ||
           (sym == video_pkg::ctrl_10) || (sym == video_pkg::ctrl_11);
  endfunction

  // sink side, undo inversion then undo xor or xnor chain
  function automatic logic [7:0] decode_symbol(input logic [9:0] sym);
    logic [7:0] word;
    logic [7:0] value;
    word = sym[9] ? ~sym[7:0] : sym[7:0];
    value[0] = word[0];
    for (int i = 1; i < 8; i++)
    begin
      value[i] = sym[8] ? (word[i] ^ word[i-1]) : ~(word[i] ^ word[i-1]);
    end
    return value;
  endfunction

  // reference DVI encoder, disp is ones minus zeros so far
  task automatic encode_model(input logic [7:0] d, inout int disp, output logic [9:0] sym);
    int ones_d;
    int ones_q;
    int diff;
    logic [8:0] q;
    ones_d = 0;
    ones_q = 0;
    for (int i = 0; i < 8; i++)
    begin
      if (d[i])
      begin
        ones_d++;
      end
    end
    q[8] = !((ones_d > 4) || ((ones_d == 4) && (d[0] == 1'b0)));
    q[0] = d[0];
    for (int i = 1; i < 8; i++)
    begin
      q[i] = q[8] ? (q[i-1] ^ d[i]) : ~(q[i-1] ^ d[i]);
    end
    for (int i = 0; i < 8; i++)
    begin
      if (q[i])
      begin
        ones_q++;
      end
    end
    diff = 2 * ones_q - 8;
    if ((disp == 0) || (diff == 0))
    begin
      sym = {~q[8], q[8], q[8] ? q[7:0] : ~q[7:0]};
      disp = q[8] ? disp + diff : disp - diff;
    end
    else if (((disp > 0) && (diff > 0)) || ((disp < 0) && (diff < 0)))
    begin
      sym = {1'b1, q[8], ~q[7:0]};
      disp = disp + (q[8] ? 2 : 0) - diff;
    end
    else
    begin
      sym = {1'b0, q[8], q[7:0]};
      disp = disp - (q[8] ? 0 : 2) + diff;
    end
  endtask

  // samples on falling edges until led[idx] moves to level
  task automatic wait_led_edge(input int idx, input logic level, input int limit,
                               input string what);
    int waited;
    logic last;
    logic found;
    waited = 0;
    found = 1'b0;
    last = led[idx];
    while (!found)
    begin
      @(negedge clk_25mhz);
      waited++;
      found = (led[idx] === level) && (last !== level);
      last = led[idx];
      if (!found && (waited > limit))
      begin
        report_timeout(what);
      end
    end
  endtask

  task automatic check_reset_state(input string phase);
    if (led !== 8'b0000_0100)
    begin
      report_mismatch({phase, " leds"}, 32'(8'b0000_0100), 32'(led));
    end
    if (tmds !== {video_pkg::ctrl_00, video_pkg::ctrl_00, video_pkg::ctrl_00})
    begin
      report_mismatch({phase, " symbols"}, 32'({3{video_pkg::ctrl_00}}), 32'(tmds));
    end
    if (user_programn !== 1'b0)
    begin
      report_mismatch({phase, " user_programn"}, 32'(0), 32'(user_programn));
    end
  endtask

  // blanking symbols follow the sync seen one cycle earlier
  always @(negedge clk_25mhz)
  begin
    if (monitor_on && prev_led[2])
    begin
      expected_blue = control_code({prev_led[0], prev_led[1]});
      if (tmds !== {video_pkg::ctrl_00, video_pkg::ctrl_00, expected_blue})
      begin
        report_mismatch("blanking symbols",
                        32'({video_pkg::ctrl_00, video_pkg::ctrl_00, expected_blue}),
                        32'(tmds));
      end
    end
    prev_led <= led;
  end

  task automatic check_frame_geometry;
    int hsync_edges;
    int high_cycles;
    logic [7:0] last;
    logic done;
    wait_led_edge(0, 1'b1, frame_limit, "vsync rising edge");
    hsync_edges = 0;
    cycles = 0;
    done = 1'b0;
    last = led;
    while (!done)
    begin
      @(negedge clk_25mhz);
      cycles++;
      if (led[1] && !last[1])
      begin
        hsync_edges++;
      end
      done = led[0] && !last[0];
      last = led;
      if (!done && (cycles > frame_limit))
      begin
        report_timeout("the next vsync rising edge");
      end
    end
    if (hsync_edges != video_pkg::v_total)
    begin
      report_mismatch("hsync pulses per frame", 32'(video_pkg::v_total), 32'(hsync_edges));
    end
    // one line, from hsync rise to hsync rise
    wait_led_edge(1, 1'b1, 2 * video_pkg::h_total, "hsync rising edge");
    cycles = 0;
    high_cycles = 1;
    done = 1'b0;
    last = led;
    while (!done)
    begin
      @(negedge clk_25mhz);
      cycles++;
      done = led[1] && !last[1];
      if (!done && led[1])
      begin
        high_cycles++;
      end
      last = led;
      if (!done && (cycles > 2 * video_pkg::h_total))
      begin
        report_timeout("the next hsync rising edge");
      end
    end
    if (cycles != video_pkg::h_total)
    begin
      report_mismatch("cycles per line", 32'(video_pkg::h_total), 32'(cycles));
    end
    if (high_cycles != video_pkg::h_sync)
    begin
      report_mismatch("hsync width", 32'(video_pkg::h_sync), 32'(high_cycles));
    end
  endtask

  task automatic check_line(input int line_y);
    int active;
    int disp;
    logic [9:0] sym;
    logic [9:0] model_sym;
    logic [7:0] want;
    wait_led_edge(0, 1'b1, frame_limit, "vsync before the line capture");
    // blank falls line_y + 1 times to reach the chosen line
    for (int k = 0; k <= line_y; k++)
    begin
      wait_led_edge(2, 1'b0, frame_limit, "start of a visible line");
    end
    // symbols trail the leds by one cycle
    for (int c = 0; c < video_pkg::h_total; c++)
    begin
      @(negedge clk_25mhz);
      captured[c] = tmds;
    end
    // lane 0 is blue, 1 green, 2 red
    for (int ch = 0; ch < 3; ch++)
    begin
      active = 0;
      disp = 0;
      for (int c = 0; c < video_pkg::h_total; c++)
      begin
        sym = captured[c][ch*10 +: 10];
        if (!is_control(sym) && (active < video_pkg::h_active))
        begin
          want = bar_colors[active / video_pkg::bar_width][ch*8 +: 8];
          encode_model(want, disp, model_sym);
          if (decode_symbol(sym) !== want)
          begin
            report_mismatch($sformatf("line %0d %s pixel %0d decode", line_y,
                                      lane_name[ch], active), 32'(want),
                            32'(decode_symbol(sym)));
          end
          if (sym !== model_sym)
          begin
            report_mismatch($sformatf("line %0d %s pixel %0d symbol", line_y,
                                      lane_name[ch], active), 32'(model_sym), 32'(sym));
          end
        end
        if (!is_control(sym))
        begin
          active++;
        end
      end
      if (active != video_pkg::h_active)
      begin
        report_mismatch($sformatf("line %0d %s active symbols", line_y, lane_name[ch]),
                        32'(video_pkg::h_active), 32'(active));
      end
    end
  endtask

  initial
  begin
    seed = $urandom(99388);
    rst_n = 1'b0;
    btn = '0;
    // btn, expected user_programn, expected wifi_gpio0
    board_rows[0] = '{btn: 7'h00, user_programn: 1'b0, wifi_gpio0: 1'b0};
    board_rows[1] = '{btn: 7'h01, user_programn: 1'b1, wifi_gpio0: 1'b1};
    board_rows[2] = '{btn: 7'h7e, user_programn: 1'b0, wifi_gpio0: 1'b0};
    board_rows[3] = '{btn: 7'h7f, user_programn: 1'b1, wifi_gpio0: 1'b1};
    board_rows[4] = '{btn: 7'h00, user_programn: 1'b0, wifi_gpio0: 1'b0};
    // black, blue, green, cyan, red, magenta, yellow, white
    bar_colors[0] = '{red: 8'h00, green: 8'h00, blue: 8'h00};
    bar_colors[1] = '{red: 8'h00, green: 8'h00, blue: 8'hff};
    bar_colors[2] = '{red: 8'h00, green: 8'hff, blue: 8'h00};
    bar_colors[3] = '{red: 8'h00, green: 8'hff, blue: 8'hff};
    bar_colors[4] = '{red: 8'hff, green: 8'h00, blue: 8'h00};
    bar_colors[5] = '{red: 8'hff, green: 8'h00, blue: 8'hff};
    bar_colors[6] = '{red: 8'hff, green: 8'hff, blue: 8'h00};
    bar_colors[7] = '{red: 8'hff, green: 8'hff, blue: 8'hff};
    lane_name[0] = "blue";
    lane_name[1] = "green";
    lane_name[2] = "red";

    // two cycles of reset, checked in the middle
    @(posedge clk_25mhz);
    @(negedge clk_25mhz);
    check_reset_state("during reset");
    @(posedge clk_25mhz);
    #5 rst_n = 1'b1;
    @(posedge clk_25mhz);
    @(negedge clk_25mhz);
    check_reset_state("after reset");
    monitor_on = 1'b1;

    // button table, well inside the reload delay
    for (int r = 0; r < 5; r++)
    begin
      @(posedge clk_25mhz);
      #5 btn = board_rows[r].btn;
      @(negedge clk_25mhz);
      if (user_programn !== board_rows[r].user_programn)
      begin
        report_mismatch($sformatf("board row %0d user_programn", r),
                        32'(board_rows[r].user_programn), 32'(user_programn));
      end
      if (wifi_gpio0 !== board_rows[r].wifi_gpio0)
      begin
        report_mismatch($sformatf("board row %0d wifi_gpio0", r),
                        32'(board_rows[r].wifi_gpio0), 32'(wifi_gpio0));
      end
    end

    // button released, program line waits for the timer
    cycles = 0;
    while (user_programn !== 1'b1)
    begin
      @(negedge clk_25mhz);
      cycles++;
      if (cycles > reload_cycles + 1000)
      begin
        report_timeout("user_programn after the reload delay");
      end
    end
    if (cycles_since_reset < reload_cycles)
    begin
      failure_count++;
      $display("Failure: user_programn rose %0d cycles after reset, before the reload delay",
               cycles_since_reset);
    end

    check_frame_geometry();
    check_line(int'($urandom % video_pkg::v_active));
    check_line(int'($urandom % video_pkg::v_active));

    $display("Summary: %0d value mismatches, %0d other failures", mismatch_count,
             failure_count);
    if ((mismatch_count == 0) && (failure_count == 0))
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/dvi_test_top.sv
`timescale 1ns/1ps
`default_nettype none

module dvi_test_top (
  input  wire                      clk_25mhz,
  input  wire                      rst_n,
  input  wire                [6:0] btn,
  output logic               [7:0] led,
  output video_pkg::tmds_symbols_t tmds,
  output logic                     user_programn,
  output logic                     wifi_gpio0
);

  // raw timing from the counters
  video_pkg::video_sync_t timing_sync;
  video_pkg::video_pos_t timing_pos;

  // pattern output, sync aligned with colour
  video_pkg::video_sync_t bars_sync;
  video_pkg::rgb_t bars_rgb;

  // encoded lanes
  logic [9:0] sym_red;
  logic [9:0] sym_green;
  logic [9:0] sym_blue;

  video_timing u_timing (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .sync      (timing_sync),
    .pos       (timing_pos)
  );

  color_bars u_bars (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .sync_in   (timing_sync),
    .pos       (timing_pos),
    .sync      (bars_sync),
    .rgb       (bars_rgb)
  );

  // only the blue lane carries sync during blanking
  tmds_encoder u_enc_red (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .data      (bars_rgb.red),
    .blank     (bars_sync.blank),
    .ctrl      (2'b00),
    .symbol    (sym_red)
  );

  tmds_encoder u_enc_green (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .data      (bars_rgb.green),
    .blank     (bars_sync.blank),
    .ctrl      (2'b00),
    .symbol    (sym_green)
  );

  // c1 is vsync, c0 is hsync
  tmds_encoder u_enc_blue (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .data      (bars_rgb.blue),
    .blank     (bars_sync.blank),
    .ctrl      ({bars_sync.vsync, bars_sync.hsync}),
    .symbol    (sym_blue)
  );

  board_control u_board (
    .clk_25mhz     (clk_25mhz),
    .rst_n         (rst_n),
    .btn0          (btn[0]),
    .user_programn (user_programn),
    .wifi_gpio0    (wifi_gpio0)
  );

  assign tmds = '{red: sym_red, green: sym_green, blue: sym_blue};

  // status lights, one cycle ahead of the symbols
  assign led = {5'b00000, bars_sync.blank, bars_sync.hsync, bars_sync.vsync};

endmodule

`default_nettype wire

//--- design/board_control.sv
`timescale 1ns/1ps
`default_nettype none

module board_control (
  input  wire  clk_25mhz,
  input  wire  rst_n,
  input  wire  btn0,
  output logic user_programn,
  output logic wifi_gpio0
);

  // guard timer after reset, about 21 ms at 25 MHz
  logic [video_pkg::reload_delay_bits-1:0] reload_cnt;

  // set once the top bit is reached
  logic reload_done;

  assign reload_done = reload_cnt[video_pkg::reload_delay_bits-1];

  // climb from reset, then hold
  always_ff @(posedge clk_25mhz or negedge rst_n)
  begin
    if (!rst_n)
    begin
      reload_cnt <= '0;
    end
    else if (!reload_done)
    begin
      reload_cnt <= reload_cnt + 1'b1;
    end
  end

  // button or finished timer releases the program line
  assign user_programn = btn0 | reload_done;

  // holding the button hands the board over to the wifi module
  assign wifi_gpio0 = btn0;

endmodule

`default_nettype wire

//--- design/tmds_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder (
  input  wire        clk_25mhz,
  input  wire        rst_n,
  input  wire  [7:0] data,
  input  wire        blank,
  input  wire  [1:0] ctrl,
  output logic [9:0] symbol
);

  // number of set bits in a byte
  function automatic logic [3:0] count_ones(input logic [7:0] value);
    logic [3:0] total;
    total = '0;
    for (int i = 0; i < 8; i++)
    begin
      total = total + 4'(value[i]);
    end
    return total;
  endfunction

  // transition minimizing stage
  logic [3:0] n1_data;
  logic use_xnor;
  logic [8:0] q_m;

  // dc balance stage
  logic [3:0] n1_q;
  logic signed [5:0] balance;
  logic signed [5:0] q_m8_twice;
  logic signed [5:0] not_q_m8_twice;
  logic signed [5:0] disparity;
  logic signed [5:0] disparity_next;
  logic [9:0] symbol_next;

  assign n1_data = count_ones(data);
  // xnor when the byte is mostly ones, ties broken by bit 0
  assign use_xnor = (n1_data > 4'd4) || ((n1_data == 4'd4) && !data[0]);

  always_comb
  begin
    q_m[0] = data[0];
    for (int i = 1; i < 8; i++)
    begin
      q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
    end
    // bit 8 tells the sink which operation was used
    q_m[8] = ~use_xnor;
  end

  assign n1_q = count_ones(q_m[7:0]);
  // ones minus zeros of the coded byte
  assign balance = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;
  assign q_m8_twice = $signed({4'b0000, q_m[8], 1'b0});
  assign not_q_m8_twice = $signed({4'b0000, ~q_m[8], 1'b0});

  always_comb
  begin
    if ((disparity == 6'sd0) || (balance == 6'sd0))
    begin
      // no bias either way, invert only when xnor coded
      symbol_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
      if (q_m[8])
      begin
        disparity_next = disparity + balance;
      end
      else
      begin
        disparity_next = disparity - balance;
      end
    end
    else if (((disparity > 6'sd0) && (balance > 6'sd0)) ||
             ((disparity < 6'sd0) && (balance < 6'sd0)))
    begin
      // same sign as the running total, so invert
      symbol_next = {1'b1, q_m[8], ~q_m[7:0]};
      disparity_next = disparity + q_m8_twice - balance;
    end
    else
    begin
      // pulls the total back toward zero as is
      symbol_next = {1'b0, q_m[8], q_m[7:0]};
      disparity_next = disparity - not_q_m8_twice + balance;
    end
  end

  always_ff @(posedge clk_25mhz or negedge rst_n)
  begin
    if (!rst_n)
    begin
      symbol <= video_pkg::ctrl_00;
      disparity <= '0;
    end
    else if (blank)
    begin
      // control period, disparity starts fresh each line
      case (ctrl)
        2'b00: symbol <= video_pkg::ctrl_00;
        2'b01: symbol <= video_pkg::ctrl_01;
        2'b10: symbol <= video_pkg::ctrl_10;
        default: symbol <= video_pkg::ctrl_11;
      endcase
      disparity <= '0;
    end
    else
    begin
      symbol <= symbol_next;
      disparity <= disparity_next;
    end
  end

endmodule

`default_nettype wire

//--- design/color_bars.sv
`timescale 1ns/1ps
`default_nettype none

module color_bars (
  input  wire                    clk_25mhz,
  input  wire                    rst_n,
  input  video_pkg::video_sync_t sync_in,
  input  video_pkg::video_pos_t  pos,
  output video_pkg::video_sync_t sync,
  output video_pkg::rgb_t        rgb
);

  // bar index 0..7 across the visible line
  logic [2:0] bar_num;

  // colour for the pixel at pos
  video_pkg::rgb_t rgb_next;

  // x beyond 639 only occurs in blanking, where the colour is masked
  assign bar_num = 3'(pos.x / video_pkg::coord_t'(video_pkg::bar_width));

  always_comb
  begin
    // index bits pick the primaries, bar 0 black and bar 7 white
    rgb_next.red = {8{bar_num[2]}};
    rgb_next.green = {8{bar_num[1]}};
    rgb_next.blue = {8{bar_num[0]}};
    // black outside active video
    if (sync_in.blank)
    begin
      rgb_next = '0;
    end
  end

  // one stage, sync delayed with the colour
  always_ff @(posedge clk_25mhz or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync <= '{hsync: 1'b0, vsync: 1'b0, blank: 1'b1};
      rgb <= '0;
    end
    else
    begin
      sync <= sync_in;
      rgb <= rgb_next;
    end
  end

endmodule

`default_nettype wire

//--- design/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing (
  input  wire                    clk_25mhz,
  input  wire                    rst_n,
  output video_pkg::video_sync_t sync,
  output video_pkg::video_pos_t  pos
);

  // free-running position counters
  video_pkg::coord_t h_cnt;
  video_pkg::coord_t v_cnt;

  // end of line and end of frame flags
  logic h_last;
  logic v_last;

  // decoded sync and blank for the current count
  video_pkg::video_sync_t sync_next;

  assign h_last = (h_cnt == video_pkg::coord_t'(video_pkg::h_total - 1));
  assign v_last = (v_cnt == video_pkg::coord_t'(video_pkg::v_total - 1));

  // x wraps every line, y advances on the last pixel of a line
  always_ff @(posedge clk_25mhz or negedge rst_n)
  begin
    if (!rst_n)
    begin
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else
    begin
      if (h_last)
      begin
        h_cnt <= '0;
        // frame wrap after line 524
        if (v_last)
        begin
          v_cnt <= '0;
        end
        else
        begin
          v_cnt <= v_cnt + 1'b1;
        end
      end
      else
      begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  always_comb
  begin
    // hsync over pixels 656 to 751
    sync_next.hsync = (h_cnt >= video_pkg::coord_t'(video_pkg::h_sync_start)) &&
                      (h_cnt < video_pkg::coord_t'(video_pkg::h_sync_end));
    // vsync over whole lines 490 and 491
    sync_next.vsync = (v_cnt >= video_pkg::coord_t'(video_pkg::v_sync_start)) &&
                      (v_cnt < video_pkg::coord_t'(video_pkg::v_sync_end));
    // visible only inside the 640x480 window
    sync_next.blank = (h_cnt >= video_pkg::coord_t'(video_pkg::h_active)) ||
                      (v_cnt >= video_pkg::coord_t'(video_pkg::v_active));
  end

  // all outputs move on the same edge
  always_ff @(posedge clk_25mhz or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // idle in blanking with no sync pulse
      sync <= '{hsync: 1'b0, vsync: 1'b0, blank: 1'b1};
      pos <= '0;
    end
    else
    begin
      sync <= sync_next;
      pos <= '{x: h_cnt, y: v_cnt};
    end
  end

endmodule

`default_nettype wire

//--- design/video_pkg.sv
`default_nettype none

package video_pkg;

  // 640x480 at 60 Hz, pixel clock is the 25 MHz board clock
  // horizontal timing in pixels
  localparam int h_active = 640;
  localparam int h_front = 16;
  localparam int h_sync = 96;
  localparam int h_back = 48;
  localparam int h_total = h_active + h_front + h_sync + h_back;

  // vertical timing in lines
  localparam int v_active = 480;
  localparam int v_front = 10;
  localparam int v_sync = 2;
  localparam int v_back = 33;
  localparam int v_total = v_active + v_front + v_sync + v_back;

  // sync pulse windows, start inclusive and end exclusive
  localparam int h_sync_start = h_active + h_front;
  localparam int h_sync_end = h_sync_start + h_sync;
  localparam int v_sync_start = v_active + v_front;
  localparam int v_sync_end = v_sync_start + v_sync;

  // coordinate width, wide enough for 799 and 524
  localparam int coord_bits = 10;

  // eight bars across 640 pixels
  localparam int bar_width = 80;

  // reload guard counter, done once the top bit sets
  localparam int reload_delay_bits = 20;

  // DVI control period symbols, indexed by {c1, c0}
  localparam logic [9:0] ctrl_00 = 10'b1101010100;
  localparam logic [9:0] ctrl_01 = 10'b0010101011;
  localparam logic [9:0] ctrl_10 = 10'b0101010100;
  localparam logic [9:0] ctrl_11 = 10'b1010101011;

  typedef logic [coord_bits-1:0] coord_t;

  // sync is active high, blank high outside the visible area
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic blank;
  } video_sync_t;

  // only meaningful while blank is low
  typedef struct packed {
    coord_t x;
    coord_t y;
  } video_pos_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  // encoded symbols of one pixel, one per channel
  typedef struct packed {
    logic [9:0] red;
    logic [9:0] green;
    logic [9:0] blue;
  } tmds_symbols_t;

endpackage

`default_nettype wire
